//--- verilog/cache_pkg.sv
package cache_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // line geometry
  localparam int words_per_line = 4;
  localparam int byte_bits = 2;
  localparam int word_bits = $clog2(words_per_line);
  localparam int line_offset_bits = byte_bits + word_bits;
  localparam int tag_width = 32 - line_offset_bits;

  // widest set index the structs can carry
  localparam int max_set_bits = 8;

  typedef word_t [words_per_line-1:0] line_t;

  typedef enum logic {
    op_read,
    op_write
  } cache_op_e;

  typedef struct packed {
    cache_op_e  op;
    addr_t      addr;
    word_t      wdata;
    logic [3:0] be;
  } cpu_req_t;

  typedef struct packed {
    logic                    valid;
    cpu_req_t                req;
    logic                    way;
    logic [max_set_bits-1:0] set;
  } lookup_to_data_t;

  typedef struct packed {
    logic                    valid;
    logic [max_set_bits-1:0] set;
    logic                    way;
    logic [tag_width-1:0]    tag;
    line_t                   line;
  } fill_t;

  typedef struct packed {
    logic                    dirty;
    logic [max_set_bits-1:0] set;
    logic                    way;
    logic [tag_width-1:0]    tag;
  } victim_t;

  typedef enum logic [2:0] {
    ms_idle,
    ms_wb_req,
    ms_wb_data,
    ms_fill_req,
    ms_fill_wait,
    ms_done
  } miss_state_e;

endpackage

//--- verilog/cache_lookup_stage.sv
module cache_lookup_stage
  import cache_pkg::*;
#(
  parameter int num_sets = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  cpu_req_t        req,
  input  logic            rd,
  input  logic            wr,
  input  fill_t           fill,
  input  logic            miss_busy,
  output logic            waitrequest,
  output lookup_to_data_t to_data,
  output logic            miss_start,
  output addr_t           miss_addr,
  output victim_t         victim
);

  localparam int set_bits = $clog2(num_sets);

  logic [tag_width-1:0] tag_array [num_sets][2];
  logic [1:0] valid_bits [num_sets];
  logic [1:0] dirty_bits [num_sets];
  // way to replace next in each set
  logic lru_bits [num_sets];

  cpu_req_t slot;
  logic slot_valid;
  logic miss_waiting;
  logic [set_bits-1:0] slot_set;
  logic [set_bits-1:0] fill_set;
  logic [tag_width-1:0] slot_tag;
  logic [1:0] way_hit;
  logic hit;
  logic hit_way;
  logic victim_way;
  logic accept;
  logic start_miss;

  logic out_valid;
  cpu_req_t out_req;
  logic out_way;
  logic [set_bits-1:0] out_set;

  assign slot_set = slot.addr[line_offset_bits +: set_bits];
  assign slot_tag = tag_width'(slot.addr >> (line_offset_bits + set_bits));
  assign fill_set = fill.set[set_bits-1:0];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_bits[slot_set][w] && (tag_array[slot_set][w] == slot_tag);
    end
  end

  assign hit = slot_valid && (|way_hit);
  assign hit_way = way_hit[1];
  assign victim_way = lru_bits[slot_set];

  // a held slot that misses blocks the cpu until the refill replays it
  assign waitrequest = slot_valid && !hit;
  assign accept = (rd || wr) && !waitrequest;
  assign start_miss = slot_valid && !hit && !miss_waiting && !miss_busy;

  assign to_data = '{valid: out_valid, req: out_req, way: out_way,
                     set: max_set_bits'(out_set)};

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= 1'b0;
      miss_waiting <= 1'b0;
      miss_start <= 1'b0;
      out_valid <= 1'b0;
      for (int s = 0; s < num_sets; s++) begin
        valid_bits[s] <= 2'b00;
        dirty_bits[s] <= 2'b00;
        lru_bits[s] <= 1'b0;
      end
    end else begin
      out_valid <= hit;
      miss_start <= start_miss;
      if (accept) begin
        slot_valid <= 1'b1;
      end else if (hit) begin
        slot_valid <= 1'b0;
      end
      if (hit) begin
        lru_bits[slot_set] <= !hit_way;
        if (slot.op == op_write) begin
          dirty_bits[slot_set][hit_way] <= 1'b1;
        end
      end
      if (start_miss) begin
        miss_waiting <= 1'b1;
      end
      if (fill.valid) begin
        valid_bits[fill_set][fill.way] <= 1'b1;
        dirty_bits[fill_set][fill.way] <= 1'b0;
        miss_waiting <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      slot <= req;
    end
    if (hit) begin
      out_req <= slot;
      out_way <= hit_way;
      out_set <= slot_set;
    end
    if (fill.valid) begin
      tag_array[fill_set][fill.way] <= fill.tag;
    end
    if (start_miss) begin
      miss_addr <= slot.addr;
      victim <= '{dirty: dirty_bits[slot_set][victim_way], set: max_set_bits'(slot_set),
                  way: victim_way, tag: tag_array[slot_set][victim_way]};
    end
  end

  // only one refill may be outstanding at a time
  miss_start_idle: assert property (@(posedge clock) disable iff (reset)
    miss_start |-> !miss_busy);

endmodule

//--- verilog/cache_data_stage.sv
module cache_data_stage
  import cache_pkg::*;
#(
  parameter int num_sets = 16
) (
  input  logic                    clock,
  input  logic                    reset,
  input  lookup_to_data_t         in,
  input  fill_t                   fill,
  input  logic [max_set_bits-1:0] victim_set,
  input  logic                    victim_way,
  output word_t                   rd_data,
  output logic                    rd_valid,
  output line_t                   victim_line
);

  localparam int set_bits = $clog2(num_sets);

  line_t line_array [num_sets][2];

  logic [set_bits-1:0] in_set;
  logic [set_bits-1:0] fill_set;
  logic [word_bits-1:0] in_word;
  word_t cur_word;
  word_t merged_word;
  logic is_read;
  logic is_write;

  assign in_set = in.set[set_bits-1:0];
  assign fill_set = fill.set[set_bits-1:0];
  assign in_word = in.req.addr[byte_bits +: word_bits];
  assign is_read = in.valid && (in.req.op == op_read);
  assign is_write = in.valid && (in.req.op == op_write);

  assign cur_word = line_array[in_set][in.way][in_word];

  // byte lanes not enabled keep the stored value
  always_comb begin
    merged_word = cur_word;
    for (int b = 0; b < 4; b++) begin
      if (in.req.be[b]) begin
        merged_word[8*b +: 8] = in.req.wdata[8*b +: 8];
      end
    end
  end

  // read by the miss engine a cycle after the miss is raised
  assign victim_line = line_array[victim_set[set_bits-1:0]][victim_way];

  always_ff @(posedge clock) begin
    if (fill.valid) begin
      line_array[fill_set][fill.way] <= fill.line;
    end
    if (is_write) begin
      line_array[in_set][in.way][in_word] <= merged_word;
    end
    if (is_read) begin
      rd_data <= cur_word;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= is_read;
    end
  end

  // a refill only lands on a way that no write in flight is targeting
  fill_write_apart: assert property (@(posedge clock) disable iff (reset)
    !(fill.valid && is_write && (fill.set == in.set) && (fill.way == in.way)));

endmodule

//--- verilog/cache_miss_engine.sv
module cache_miss_engine
  import cache_pkg::*;
#(
  parameter int num_sets = 16
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    miss_start,
  input  addr_t   miss_addr,
  input  victim_t victim,
  input  line_t   victim_line,
  input  logic    mem_waitrequest,
  input  word_t   mem_rd_data,
  input  logic    mem_rd_valid,
  output logic    miss_busy,
  output fill_t   fill,
  output addr_t   mem_addr,
  output logic    mem_rd,
  output logic    mem_wr,
  output word_t   mem_wr_data
);

  localparam int set_bits = $clog2(num_sets);

  miss_state_e state;
  logic [word_bits-1:0] beat;
  logic last_beat;

  victim_t victim_q;
  addr_t fill_addr;
  addr_t wb_addr;
  line_t wb_line;
  line_t fill_line;

  assign last_beat = (beat == word_bits'(words_per_line - 1));

  // victim line base rebuilt from its tag and set
  assign wb_addr = (addr_t'(victim_q.tag) << (line_offset_bits + set_bits))
                 | (addr_t'(victim_q.set[set_bits-1:0]) << line_offset_bits);

  assign miss_busy = (state != ms_idle);
  assign mem_wr = (state == ms_wb_data);
  assign mem_rd = (state == ms_fill_req);
  assign mem_addr = mem_wr ? wb_addr : fill_addr;
  assign mem_wr_data = wb_line[beat];

  assign fill = '{valid: (state == ms_done), set: victim_q.set, way: victim_q.way,
                  tag: tag_width'(fill_addr >> (line_offset_bits + set_bits)),
                  line: fill_line};

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ms_idle;
      beat <= '0;
    end else begin
      case (state)
        ms_idle: begin
          if (miss_start) begin
            state <= victim.dirty ? ms_wb_req : ms_fill_req;
          end
        end
        ms_wb_req: begin
          beat <= '0;
          state <= ms_wb_data;
        end
        ms_wb_data: begin
          if (!mem_waitrequest) begin
            beat <= beat + 1'b1;
            if (last_beat) begin
              state <= ms_fill_req;
            end
          end
        end
        ms_fill_req: begin
          if (!mem_waitrequest) begin
            beat <= '0;
            state <= ms_fill_wait;
          end
        end
        ms_fill_wait: begin
          if (mem_rd_valid) begin
            beat <= beat + 1'b1;
            if (last_beat) begin
              state <= ms_done;
            end
          end
        end
        ms_done: state <= ms_idle;
        default: state <= ms_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == ms_idle) && miss_start) begin
      victim_q <= victim;
      fill_addr <= {miss_addr[31:line_offset_bits], {line_offset_bits{1'b0}}};
    end
    if (state == ms_wb_req) begin
      wb_line <= victim_line;
    end
    if ((state == ms_fill_wait) && mem_rd_valid) begin
      fill_line[beat] <= mem_rd_data;
    end
  end

  rd_wr_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(mem_rd && mem_wr));

  // memory only streams data back while a refill is collecting it
  rd_valid_in_fill: assert property (@(posedge clock) disable iff (reset)
    mem_rd_valid |-> (state == ms_fill_wait));

endmodule

//--- verilog/burst_memory.sv
module burst_memory
  import cache_pkg::*;
#(
  parameter int mem_words = 4096,
  parameter int mem_latency = 3
) (
  input  logic  clock,
  input  logic  reset,
  input  addr_t addr,
  input  logic  rd,
  input  logic  wr,
  input  word_t wr_data,
  output logic  waitrequest,
  output word_t rd_data,
  output logic  rd_valid
);

  localparam int idx_bits = $clog2(mem_words);
  localparam int lat_bits = $clog2(mem_latency + 2);
  localparam int cnt_bits = $clog2(words_per_line + 1);

  word_t mem_array [mem_words];

  logic [lat_bits-1:0] wait_cnt;
  logic [cnt_bits-1:0] wr_left;
  logic [cnt_bits-1:0] rd_left;
  logic [idx_bits-1:0] wr_ptr;
  logic [idx_bits-1:0] rd_ptr;
  logic [idx_bits-1:0] addr_idx;
  logic [idx_bits-1:0] wr_idx;
  logic ready;

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem_array[i] = word_t'(i);
    end
  end

  assign addr_idx = addr[byte_bits +: idx_bits];
  // later beats of a write burst go straight in
  assign ready = (wr_left != 0) || ((rd_left == 0) && (wait_cnt == lat_bits'(mem_latency)));
  assign waitrequest = !ready;
  assign wr_idx = (wr_left == 0) ? addr_idx : wr_ptr;

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_cnt <= '0;
      wr_left <= '0;
      rd_left <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= (rd_left != 0);
      if (rd_left != 0) begin
        rd_left <= rd_left - 1'b1;
      end
      if (rd && ready) begin
        rd_left <= cnt_bits'(words_per_line);
      end
      if (wr && ready) begin
        wr_left <= (wr_left == 0) ? cnt_bits'(words_per_line - 1) : wr_left - 1'b1;
      end
      if ((rd || wr) && ready) begin
        wait_cnt <= '0;
      end else if ((rd || wr) && (wait_cnt != lat_bits'(mem_latency))) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr && ready) begin
      mem_array[wr_idx] <= wr_data;
      wr_ptr <= wr_idx + 1'b1;
    end
    if (rd && ready) begin
      rd_ptr <= addr_idx;
    end else if (rd_left != 0) begin
      rd_data <= mem_array[rd_ptr];
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- verilog/cache_top.sv
module cache_top
  import cache_pkg::*;
#(
  parameter int num_sets = 16,
  parameter int mem_words = 4096,
  parameter int mem_latency = 3
) (
  input  logic     clock,
  input  logic     reset,
  input  cpu_req_t req,
  input  logic     rd,
  input  logic     wr,
  output logic     waitrequest,
  output word_t    rd_data,
  output logic     rd_valid
);

  lookup_to_data_t to_data;
  fill_t fill;
  victim_t victim;
  line_t victim_line;
  addr_t miss_addr;
  logic miss_start;
  logic miss_busy;

  addr_t mem_addr;
  word_t mem_wr_data;
  word_t mem_rd_data;
  logic mem_rd;
  logic mem_wr;
  logic mem_waitrequest;
  logic mem_rd_valid;

  cache_lookup_stage #(.num_sets(num_sets)) lookup (
    .clock(clock), .reset(reset), .req(req), .rd(rd), .wr(wr), .fill(fill),
    .miss_busy(miss_busy), .waitrequest(waitrequest), .to_data(to_data),
    .miss_start(miss_start), .miss_addr(miss_addr), .victim(victim)
  );

  cache_data_stage #(.num_sets(num_sets)) data (
    .clock(clock), .reset(reset), .in(to_data), .fill(fill),
    .victim_set(victim.set), .victim_way(victim.way),
    .rd_data(rd_data), .rd_valid(rd_valid), .victim_line(victim_line)
  );

  cache_miss_engine #(.num_sets(num_sets)) miss (
    .clock(clock), .reset(reset), .miss_start(miss_start), .miss_addr(miss_addr),
    .victim(victim), .victim_line(victim_line), .mem_waitrequest(mem_waitrequest),
    .mem_rd_data(mem_rd_data), .mem_rd_valid(mem_rd_valid), .miss_busy(miss_busy),
    .fill(fill), .mem_addr(mem_addr), .mem_rd(mem_rd), .mem_wr(mem_wr),
    .mem_wr_data(mem_wr_data)
  );

  burst_memory #(.mem_words(mem_words), .mem_latency(mem_latency)) memory (
    .clock(clock), .reset(reset), .addr(mem_addr), .rd(mem_rd), .wr(mem_wr),
    .wr_data(mem_wr_data), .waitrequest(mem_waitrequest), .rd_data(mem_rd_data),
    .rd_valid(mem_rd_valid)
  );

endmodule

//--- bench/cache_tb.sv
module cache_tb
  import cache_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_sets = 16;
  localparam int mem_words = 4096;
  localparam int mem_latency = 3;

  // op, address, write data, byte enables, expected read word
  localparam int num_records = 36;
  localparam int fields = 5;
  localparam int cycle_limit = num_records * 40 + 100;
  localparam int drain_limit = 40;
  localparam int drive_delay = 1;

  logic clock;
  logic reset;
  cpu_req_t req;
  logic rd;
  logic wr;
  logic waitrequest;
  word_t rd_data;
  logic rd_valid;

  logic [31:0] golden [num_records * fields];
  word_t expected_q [$];
  int error_count;
  int reads_accepted;
  int reads_returned;
  int cycle_count;
  logic in_reset_window;

  cache_top #(
    .num_sets(num_sets),
    .mem_words(mem_words),
    .mem_latency(mem_latency)
  ) dut (
    .clock(clock),
    .reset(reset),
    .req(req),
    .rd(rd),
    .wr(wr),
    .waitrequest(waitrequest),
    .rd_data(rd_data),
    .rd_valid(rd_valid)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic print_summary();
    $display("summary: %0d reads accepted, %0d reads returned, %0d errors",
             reads_accepted, reads_returned, error_count);
  endtask

  task automatic run_access(input int index);
    int base;
    logic [31:0] op_field;
    logic accepted;
    base = index * fields;
    op_field = golden[base];
    assert (op_field == 32'd0 || op_field == 32'd1) else begin
      $display("golden record %0d holds an unknown opcode %h", index, op_field);
      error_count++;
    end
    req.op = (op_field == 32'd1) ? op_write : op_read;
    req.addr = golden[base + 1];
    req.wdata = golden[base + 2];
    req.be = golden[base + 3][3:0];
    rd = (op_field != 32'd1);
    wr = (op_field == 32'd1);
    accepted = 1'b0;
    // waitrequest only moves at a rising edge, so mid-cycle is a stable sample
    while (!accepted) begin
      @(negedge clock);
      accepted = !waitrequest;
      @(posedge clock);
    end
    if (rd) begin
      expected_q.push_back(golden[base + 4]);
      reads_accepted++;
    end
    #(drive_delay);
    rd = 1'b0;
    wr = 1'b0;
  endtask

  // read data is compared in the middle of the cycle that carries rd_valid
  always @(negedge clock) begin : read_check
    word_t expected_word;
    if (reset || in_reset_window) begin
      assert (!rd_valid) else begin
        $display("Fail at %0t: rd_valid = %b around reset, expected 0", $time, rd_valid);
        error_count++;
      end
      assert (!waitrequest) else begin
        $display("Fail at %0t: waitrequest = %b around reset, expected 0", $time,
                 waitrequest);
        error_count++;
      end
    end
    in_reset_window = reset;
    if (rd_valid) begin
      assert (expected_q.size() != 0) else begin
        $display("rd_valid pulsed at %0t while no read was outstanding", $time);
        error_count++;
      end
      if (expected_q.size() != 0) begin
        expected_word = expected_q.pop_front();
        reads_returned++;
        assert (rd_data === expected_word) else begin
          $display("Fail at %0t: rd_data = %h, expected %h", $time, rd_data, expected_word);
          error_count++;
        end
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    print_summary();
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    int drain_cycles;
    reset = 1'b1;
    rd = 1'b0;
    wr = 1'b0;
    req = '0;
    error_count = 0;
    reads_accepted = 0;
    reads_returned = 0;
    in_reset_window = 1'b1;
    $readmemh("bench/cache_golden.mem", golden);
    repeat (4) @(posedge clock);
    #(drive_delay);
    reset = 1'b0;
    for (int i = 0; i < num_records; i++) begin
      run_access(i);
    end
    // drain reads still in flight
    drain_cycles = 0;
    while (expected_q.size() != 0 && drain_cycles < drain_limit) begin
      @(posedge clock);
      drain_cycles++;
    end
    // idle cycles catch any extra rd_valid
    repeat (8) @(posedge clock);
    assert (expected_q.size() == 0) else begin
      $display("%0d accepted reads never returned data", expected_q.size());
      error_count++;
    end
    print_summary();
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- cache_sys.f
verilog/cache_pkg.sv
verilog/cache_lookup_stage.sv
verilog/cache_data_stage.sv
verilog/cache_miss_engine.sv
verilog/burst_memory.sv
verilog/cache_top.sv
bench/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cache_tb -Mdir obj_dir -o cache_sim -f cache_sys.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/cache_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

//--- bench/cache_golden.mem
// columns: op (0 read, 1 write), byte address, write data, byte enables, expected read word
// memory starts with each word holding its word index, so cold reads expect address / 4
0 00000000 00000000 0 00000000
0 00000104 00000000 0 00000041
0 00000a5c 00000000 0 00000297
1 00000048 cafef00d f 00000000
0 00000048 00000000 0 cafef00d
0 0000004c 00000000 0 00000013
0 00000040 00000000 0 00000010
1 00000044 12345678 f 00000000
0 00000044 00000000 0 12345678
1 00000044 aabbccdd 3 00000000
0 00000044 00000000 0 1234ccdd
1 00000104 556677ee 9 00000000
0 00000104 00000000 0 550000ee
1 00000a58 01020304 4 00000000
0 00000a58 00000000 0 00020296
1 00000030 deadbeef f 00000000
1 00000134 0badc0de f 00000000
0 00000238 00000000 0 0000008e
0 00000030 00000000 0 deadbeef
0 00000134 00000000 0 0badc0de
0 00000034 00000000 0 0000000d
0 00000130 00000000 0 0000004c
0 00000048 00000000 0 cafef00d
0 00000004 00000000 0 00000001
0 00000a5c 00000000 0 00000297
0 00000104 00000000 0 550000ee
0 0000003c 00000000 0 0000000f
0 00000044 00000000 0 1234ccdd
0 00000138 00000000 0 0000004e
0 0000000c 00000000 0 00000003
0 00000030 00000000 0 deadbeef
0 00000a50 00000000 0 00000294
0 00000208 00000000 0 00000082
0 00000104 00000000 0 550000ee
1 00000000 77778888 c 00000000
0 00000000 00000000 0 77770000
